// File: common/bpu_cfg.svh
`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

// datapath
`define BPU_XLEN            32
`define BPU_HIST_LEN        16   // global history bits

// direction tables
`define BPU_BIM_ENTRIES     512
`define BPU_TAGGED_ENTRIES  256  // per tagged table
`define BPU_TAG_WIDTH       10
`define BPU_PTAG_BITS       6    // upper tag bits compared on lookup

// return stack
`define BPU_RAS_DEPTH       64

`endif

// File: common/bpu_pkg.sv
`include "bpu_cfg.svh"

package bpu_pkg;

    typedef logic [`BPU_XLEN-1:0]     addr_t;
    typedef logic [`BPU_HIST_LEN-1:0] hist_t;
    typedef logic [1:0]               ctr_t;   // msb is the taken guess
    typedef logic [`BPU_TAG_WIDTH-1:0] tag_t;
    typedef logic [$clog2(`BPU_TAGGED_ENTRIES)-1:0] tidx_t;

    // which component gave the direction
    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

    // one slot of a tagged table
    typedef struct packed {
        tag_t tag;
        ctr_t ctr;
    } tag_entry_t;

    localparam ctr_t CTR_WEAK_NT = 2'b01;

    // saturating step toward the outcome
    function automatic ctr_t ctr_next(ctr_t ctr, logic taken);
        if (taken) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'b01;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'b01;
    endfunction

endpackage

// File: common/bpu_update_if.sv
`timescale 1ns/100ps

// execute-stage feedback toward the direction predictor
interface bpu_update_if;
    import bpu_pkg::*;

    logic      valid;     // one-cycle strobe
    logic      taken;     // resolved outcome
    logic      correct;   // predicted direction was right
    addr_t     pc;
    hist_t     history;   // history seen at lookup time
    provider_e provider;  // provider returned with the branch

    modport source (
        output valid, taken, correct, pc, history, provider
    );

    modport sink (
        input valid, taken, correct, pc, history, provider
    );

endinterface

// File: logic/inst_decode.sv
`timescale 1ns/100ps

module inst_decode (
    input  bpu_pkg::addr_t inst_i,
    output logic           is_branch_o,
    output logic           is_jal_o,
    output logic           is_jalr_o,
    output logic           is_ret_o,
    output bpu_pkg::addr_t jal_offset_o,
    output bpu_pkg::addr_t br_offset_o
);

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] i_imm;
    logic        rs1_link;

    assign rd    = inst_i[11:7];
    assign rs1   = inst_i[19:15];
    assign i_imm = inst_i[31:20];

    // x1 (ra) or x5 (t0) as link register
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    assign is_branch_o = (inst_i[6:0] == OP_BRANCH);
    assign is_jal_o    = (inst_i[6:0] == OP_JAL);
    assign is_jalr_o   = (inst_i[6:0] == OP_JALR);

    // plain "jalr x0, 0(ra)" form only
    assign is_ret_o = is_jalr_o && (rd == 5'd0) && rs1_link && (i_imm == 12'd0);

    // J-type immediate
    assign jal_offset_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20],
                           inst_i[30:21], 1'b0};

    // B-type immediate
    assign br_offset_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
                          inst_i[11:8], 1'b0};

endmodule

// File: tage/bimodal_table.sv
`timescale 1ns/100ps
`include "bpu_cfg.svh"

module bimodal_table (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t lookup_pc_i,
    input  logic           upd_valid_i,
    input  bpu_pkg::addr_t upd_pc_i,
    input  logic           upd_taken_i,
    output bpu_pkg::ctr_t  pred_o
);
    import bpu_pkg::*;

    localparam int ENTRIES = `BPU_BIM_ENTRIES;
    localparam int IW      = $clog2(ENTRIES);

    ctr_t          ctr_q [ENTRIES];
    logic [IW-1:0] lk_idx;
    logic [IW-1:0] upd_idx;

    // halfword aligned pc, bit 0 dropped
    assign lk_idx  = lookup_pc_i[IW:1];
    assign upd_idx = upd_pc_i[IW:1];

    assign pred_o = ctr_q[lk_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= CTR_WEAK_NT;
            end
        end else if (upd_valid_i) begin
            ctr_q[upd_idx] <= ctr_next(ctr_q[upd_idx], upd_taken_i);  // every resolved branch
        end
    end

    // outcome comes from execute, must be resolved when it arrives
    a_taken_known: assert property (@(posedge clk) disable iff (rst)
        upd_valid_i |-> !$isunknown(upd_taken_i))
        else $error("bimodal_table: update with unknown taken bit");

endmodule

// File: tage/tagged_table.sv
`timescale 1ns/100ps
`include "bpu_cfg.svh"

module tagged_table (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::tidx_t lookup_idx_i,
    input  bpu_pkg::tag_t  lookup_tag_i,
    input  bpu_pkg::tidx_t upd_idx_i,
    input  bpu_pkg::tag_t  upd_tag_i,
    input  logic           train_i,      // correct guess from this table
    input  logic           reset_ctr_i,  // wrong guess from this table
    input  logic           alloc_i,      // new entry after a base miss
    input  logic           upd_taken_i,
    output logic           hit_o,
    output bpu_pkg::ctr_t  ctr_o,
    output logic           upd_tag_match_o
);
    import bpu_pkg::*;

    localparam int ENTRIES = `BPU_TAGGED_ENTRIES;
    localparam int TW      = `BPU_TAG_WIDTH;
    localparam int PB      = `BPU_PTAG_BITS;

    tag_entry_t mem [ENTRIES];
    tag_entry_t lk_entry;
    tag_entry_t upd_entry;

    assign lk_entry  = mem[lookup_idx_i];
    assign upd_entry = mem[upd_idx_i];

    // partial match on the upper tag bits
    assign hit_o = (lk_entry.tag[TW-1 -: PB] == lookup_tag_i[TW-1 -: PB]);
    assign ctr_o = lk_entry.ctr;

    // allocation looks at the full tag
    assign upd_tag_match_o = (upd_entry.tag == upd_tag_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                mem[i] <= '{tag: '0, ctr: CTR_WEAK_NT};
            end
        end else if (train_i) begin
            mem[upd_idx_i].ctr <= ctr_next(upd_entry.ctr, upd_taken_i);
        end else if (reset_ctr_i) begin
            mem[upd_idx_i].ctr <= {2{upd_taken_i}};  // strong toward outcome
        end else if (alloc_i) begin
            // weak toward outcome
            mem[upd_idx_i] <= '{tag: upd_tag_i, ctr: {upd_taken_i, ~upd_taken_i}};
        end
    end

    // steering in the predictor must pick a single write per update
    a_one_write: assert property (@(posedge clk) disable iff (rst)
        $onehot0({train_i, reset_ctr_i, alloc_i}))
        else $error("tagged_table: more than one write operation in a cycle");

endmodule

// File: tage/tage_predictor.sv
`timescale 1ns/100ps
`include "bpu_cfg.svh"

module tage_predictor (
    input  logic               clk,
    input  logic               rst,
    input  bpu_pkg::addr_t     lookup_pc_i,
    bpu_update_if.sink         upd,
    output logic               taken_o,
    output bpu_pkg::provider_e provider_o,
    output bpu_pkg::hist_t     history_o
);
    import bpu_pkg::*;

    hist_t     hist_q;
    ctr_t      bim_ctr, t0_ctr, t1_ctr;
    logic      t0_hit, t1_hit;
    logic      t0_upd_match, t1_upd_match;
    provider_e provider;
    logic      upd_ok, upd_bad, bim_miss;

    // short slice for T0, long slice folded into T1
    function automatic tidx_t t0_index(addr_t pc, hist_t h);
        return pc[7:0] ^ h[7:0];
    endfunction

    function automatic tidx_t t1_index(addr_t pc, hist_t h);
        return pc[7:0] ^ h[15:8];
    endfunction

    function automatic tag_t t0_tag(addr_t pc, hist_t h);
        return pc[17:8] ^ h[15:6];
    endfunction

    function automatic tag_t t1_tag(addr_t pc, hist_t h);
        return pc[17:8] ^ {{(`BPU_TAG_WIDTH-8){1'b0}}, h[7:0]};
    endfunction

    // global history, newest outcome in bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (upd.valid) begin
            hist_q <= {hist_q[`BPU_HIST_LEN-2:0], upd.taken};
        end
    end

    assign history_o = hist_q;

    // longest matching history wins
    assign provider = t1_hit ? PROV_T1 : (t0_hit ? PROV_T0 : PROV_BIMODAL);
    assign provider_o = provider;

    always_comb begin
        unique case (provider)
            PROV_T1: taken_o = t1_ctr[1];
            PROV_T0: taken_o = t0_ctr[1];
            default: taken_o = bim_ctr[1];
        endcase
    end

    assign upd_ok   = upd.valid && upd.correct;
    assign upd_bad  = upd.valid && !upd.correct;
    assign bim_miss = upd_bad && (upd.provider == PROV_BIMODAL);

    bimodal_table u_bimodal (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (lookup_pc_i),
        .upd_valid_i (upd.valid),
        .upd_pc_i    (upd.pc),
        .upd_taken_i (upd.taken),
        .pred_o      (bim_ctr)
    );

    tagged_table u_t0 (
        .clk             (clk),
        .rst             (rst),
        .lookup_idx_i    (t0_index(lookup_pc_i, hist_q)),
        .lookup_tag_i    (t0_tag(lookup_pc_i, hist_q)),
        .upd_idx_i       (t0_index(upd.pc, upd.history)),
        .upd_tag_i       (t0_tag(upd.pc, upd.history)),
        .train_i         (upd_ok && (upd.provider == PROV_T0)),
        .reset_ctr_i     (upd_bad && (upd.provider == PROV_T0)),
        .alloc_i         (bim_miss && t1_upd_match && !t0_upd_match),  // T1 already owns it
        .upd_taken_i     (upd.taken),
        .hit_o           (t0_hit),
        .ctr_o           (t0_ctr),
        .upd_tag_match_o (t0_upd_match)
    );

    tagged_table u_t1 (
        .clk             (clk),
        .rst             (rst),
        .lookup_idx_i    (t1_index(lookup_pc_i, hist_q)),
        .lookup_tag_i    (t1_tag(lookup_pc_i, hist_q)),
        .upd_idx_i       (t1_index(upd.pc, upd.history)),
        .upd_tag_i       (t1_tag(upd.pc, upd.history)),
        .train_i         (upd_ok && (upd.provider == PROV_T1)),
        .reset_ctr_i     (upd_bad && (upd.provider == PROV_T1)),
        .alloc_i         (bim_miss && !t1_upd_match),  // first choice on a base miss
        .upd_taken_i     (upd.taken),
        .hit_o           (t1_hit),
        .ctr_o           (t1_ctr),
        .upd_tag_match_o (t1_upd_match)
    );

endmodule

// File: ras/return_stack.sv
`timescale 1ns/100ps
`include "bpu_cfg.svh"

module return_stack #(
    parameter int DEPTH = `BPU_RAS_DEPTH
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           push_i,
    input  bpu_pkg::addr_t push_data_i,
    input  logic           pop_i,
    output bpu_pkg::addr_t top_o,
    output logic           empty_o
);

    localparam int AW = $clog2(DEPTH);
    localparam int PW = $clog2(DEPTH + 1);  // pointer reaches DEPTH when full

    bpu_pkg::addr_t mem [DEPTH];
    logic [PW-1:0]  sp_q;       // next free slot
    logic [PW-1:0]  sp_popped;
    logic [PW-1:0]  top_ptr;
    logic           do_pop;
    logic           do_push;

    // pop of an empty stack is ignored
    assign do_pop    = pop_i && (sp_q != '0);
    assign sp_popped = sp_q - {{(PW-1){1'b0}}, do_pop};

    // push goes after the pop, full stack drops it
    assign do_push = push_i && (sp_popped < PW'(DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= sp_popped + {{(PW-1){1'b0}}, do_push};
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[sp_popped[AW-1:0]] <= push_data_i;  // reuses a slot freed this cycle
        end
    end

    assign top_ptr = sp_q - 1'b1;
    assign top_o   = mem[top_ptr[AW-1:0]];  // meaningless while empty
    assign empty_o = (sp_q == '0);

    a_sp_bound: assert property (@(posedge clk) disable iff (rst)
        sp_q <= PW'(DEPTH))
        else $error("return_stack: pointer beyond depth");

endmodule

// File: logic/target_select.sv
`timescale 1ns/100ps

module target_select (
    input  bpu_pkg::addr_t pc_i,
    input  logic           is_branch_i,
    input  logic           is_jal_i,
    input  logic           is_jalr_i,
    input  logic           is_ret_i,
    input  bpu_pkg::addr_t jal_offset_i,
    input  bpu_pkg::addr_t br_offset_i,
    input  logic           dir_taken_i,
    input  bpu_pkg::addr_t ras_top_i,
    input  logic           ras_empty_i,
    input  logic           push_valid_i,
    input  bpu_pkg::addr_t push_data_i,
    output logic           branch_o,
    output logic           taken_o,
    output bpu_pkg::addr_t target_o
);

    bpu_pkg::addr_t seq_pc;

    assign seq_pc   = pc_i + 32'd4;
    assign branch_o = is_branch_i || is_jal_i || is_jalr_i;

    always_comb begin
        taken_o  = 1'b0;
        target_o = seq_pc;  // fall-through unless something below says taken
        if (is_jal_i) begin
            taken_o  = 1'b1;
            target_o = pc_i + jal_offset_i;
        end else if (is_ret_i) begin
            if (push_valid_i) begin
                // call decoded this cycle, not yet in the stack
                taken_o  = 1'b1;
                target_o = push_data_i;
            end else if (!ras_empty_i) begin
                taken_o  = 1'b1;
                target_o = ras_top_i;
            end
        end else if (is_branch_i && dir_taken_i) begin
            taken_o  = 1'b1;
            target_o = pc_i + br_offset_i;
        end
        // other jalr forms have no target source, stay sequential
    end

endmodule

// File: logic/bpu_top.sv
`timescale 1ns/100ps
`include "bpu_cfg.svh"

module bpu_top (
    input  logic               clk,
    input  logic               rst,
    input  bpu_pkg::addr_t     if_pc_i,
    input  bpu_pkg::addr_t     if_inst_i,
    input  logic               ex_branch_valid_i,
    input  logic               ex_taken_i,
    input  logic               ex_correct_i,
    input  bpu_pkg::addr_t     ex_pc_i,
    input  bpu_pkg::hist_t     ex_history_i,
    input  bpu_pkg::provider_e ex_provider_i,
    input  bpu_pkg::addr_t     ex_inst_i,
    input  logic               id_push_valid_i,
    input  bpu_pkg::addr_t     id_push_data_i,
    input  logic               stall_i,
    output logic               branch_o,
    output logic               taken_o,
    output bpu_pkg::addr_t     target_o,
    output bpu_pkg::provider_e provider_o,
    output bpu_pkg::hist_t     history_o
);

    logic           if_branch, if_jal, if_jalr, if_ret;
    bpu_pkg::addr_t if_jal_off, if_br_off;
    logic           ex_jalr;
    logic           dir_taken;
    bpu_pkg::addr_t ras_top;
    logic           ras_empty;
    logic           ras_push, ras_pop;

    bpu_update_if u_upd_if ();

    assign u_upd_if.valid    = ex_branch_valid_i;
    assign u_upd_if.taken    = ex_taken_i;
    assign u_upd_if.correct  = ex_correct_i;
    assign u_upd_if.pc       = ex_pc_i;
    assign u_upd_if.history  = ex_history_i;
    assign u_upd_if.provider = ex_provider_i;

    inst_decode u_if_decode (
        .inst_i       (if_inst_i),
        .is_branch_o  (if_branch),
        .is_jal_o     (if_jal),
        .is_jalr_o    (if_jalr),
        .is_ret_o     (if_ret),
        .jal_offset_o (if_jal_off),
        .br_offset_o  (if_br_off)
    );

    // execute side treats any jalr through x1/x5 as a return, rd and imm unchecked
    inst_decode u_ex_decode (
        .inst_i       (ex_inst_i),
        .is_branch_o  (),
        .is_jal_o     (),
        .is_jalr_o    (ex_jalr),
        .is_ret_o     (),
        .jal_offset_o (),
        .br_offset_o  ()
    );

    assign ras_push = id_push_valid_i && !stall_i;
    assign ras_pop  = ex_branch_valid_i && ex_taken_i && !stall_i && ex_jalr &&
                      ((ex_inst_i[19:15] == 5'd1) || (ex_inst_i[19:15] == 5'd5));

    tage_predictor u_tage (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (if_pc_i),
        .upd         (u_upd_if),
        .taken_o     (dir_taken),
        .provider_o  (provider_o),
        .history_o   (history_o)
    );

    return_stack #(.DEPTH(`BPU_RAS_DEPTH)) u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push),
        .push_data_i (id_push_data_i),
        .pop_i       (ras_pop),
        .top_o       (ras_top),
        .empty_o     (ras_empty)
    );

    target_select u_select (
        .pc_i         (if_pc_i),
        .is_branch_i  (if_branch),
        .is_jal_i     (if_jal),
        .is_jalr_i    (if_jalr),
        .is_ret_i     (if_ret),
        .jal_offset_i (if_jal_off),
        .br_offset_i  (if_br_off),
        .dir_taken_i  (dir_taken),
        .ras_top_i    (ras_top),
        .ras_empty_i  (ras_empty),
        .push_valid_i (ras_push),
        .push_data_i  (id_push_data_i),
        .branch_o     (branch_o),
        .taken_o      (taken_o),
        .target_o     (target_o)
    );

endmodule

// File: verification/tb_bpu.sv
`timescale 1ns/100ps
`include "bpu_cfg.svh"

module tb_bpu;
    import bpu_pkg::*;

    logic      clk;
    logic      rst;
    addr_t     if_pc, if_inst, ex_pc, ex_inst, push_data;
    logic      ex_valid, ex_taken, ex_correct, push_valid, stall;
    hist_t     ex_hist;
    provider_e ex_prov;
    logic      branch_o, taken_o;
    addr_t     target_o;
    provider_e provider_o;
    hist_t     history_o;

    // reference model state
    logic [1:0]  m_bim [512];
    logic [9:0]  m_t0_tag [256];
    logic [1:0]  m_t0_ctr [256];
    logic [9:0]  m_t1_tag [256];
    logic [1:0]  m_t1_ctr [256];
    logic [15:0] m_hist;
    logic [31:0] m_stack [64];
    int          m_sp;

    // expected lookup results
    logic        exp_branch, exp_taken;
    logic [31:0] exp_target;
    logic [1:0]  exp_prov;
    logic [15:0] exp_hist;

    // outstanding predictions for execute replay
    logic [31:0] q_pc [$];
    logic [31:0] q_inst [$];
    logic [15:0] q_hist [$];
    logic [1:0]  q_prov [$];
    logic        q_pred [$];

    logic [31:0] rng_state = 32'h8377_37c6;
    int checks, errors, test_err, tests_run, tests_failed;

    localparam logic [31:0] NOP = 32'h0000_0013;
    localparam logic [31:0] RET = 32'h0000_8067;  // jalr x0, 0(x1)

    bpu_top u_bpu_top (
        .clk(clk), .rst(rst), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ex_branch_valid_i(ex_valid), .ex_taken_i(ex_taken), .ex_correct_i(ex_correct),
        .ex_pc_i(ex_pc), .ex_history_i(ex_hist), .ex_provider_i(ex_prov),
        .ex_inst_i(ex_inst), .id_push_valid_i(push_valid), .id_push_data_i(push_data),
        .stall_i(stall), .branch_o(branch_o), .taken_o(taken_o), .target_o(target_o),
        .provider_o(provider_o), .history_o(history_o)
    );

    always #5 clk = ~clk;

    initial begin
        #5ms;
        $display("timeout: simulation ran far too long");
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [1:0] step_ctr(logic [1:0] c, logic t);
        if (t) return (c == 2'd3) ? c : c + 2'd1;
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    function automatic logic [31:0] j_imm(logic [31:0] i);
        return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] b_imm(logic [31:0] i);
        return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    endfunction

    function automatic logic link_rs1(logic [31:0] i);
        return (i[19:15] == 5'd1) || (i[19:15] == 5'd5);
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_err++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic idle_inputs();
        if_pc = 32'h0000_1000;
        if_inst = NOP;
        ex_valid = 1'b0;
        ex_taken = 1'b0;
        ex_correct = 1'b0;
        ex_pc = '0;
        ex_hist = '0;
        ex_prov = PROV_BIMODAL;
        ex_inst = NOP;
        push_valid = 1'b0;
        push_data = '0;
        stall = 1'b0;
    endtask

    task automatic model_predict();
        logic [7:0] i0, i1;
        logic [9:0] g0, g1;
        logic       h0, h1, dir, ret, push;
        i0 = if_pc[7:0] ^ m_hist[7:0];
        i1 = if_pc[7:0] ^ m_hist[15:8];
        g0 = if_pc[17:8] ^ m_hist[15:6];
        g1 = if_pc[17:8] ^ {2'b00, m_hist[7:0]};
        h0 = (m_t0_tag[i0][9:4] == g0[9:4]);
        h1 = (m_t1_tag[i1][9:4] == g1[9:4]);
        exp_prov = h1 ? 2'd2 : (h0 ? 2'd1 : 2'd0);
        dir = h1 ? m_t1_ctr[i1][1] : (h0 ? m_t0_ctr[i0][1] : m_bim[if_pc[9:1]][1]);
        exp_hist = m_hist;
        ret = (if_inst[6:0] == 7'h67) && (if_inst[11:7] == 5'd0) && link_rs1(if_inst)
              && (if_inst[31:20] == 12'd0);
        push = push_valid && !stall;
        exp_branch = (if_inst[6:0] == 7'h63) || (if_inst[6:0] == 7'h6f)
                     || (if_inst[6:0] == 7'h67);
        exp_taken = 1'b0;
        exp_target = if_pc + 32'd4;
        if (if_inst[6:0] == 7'h6f) begin
            exp_taken = 1'b1;
            exp_target = if_pc + j_imm(if_inst);
        end else if (ret) begin
            if (push) begin
                exp_taken = 1'b1;   // same-cycle call bypass
                exp_target = push_data;
            end else if (m_sp > 0) begin
                exp_taken = 1'b1;
                exp_target = m_stack[m_sp-1];
            end
        end else if ((if_inst[6:0] == 7'h63) && dir) begin
            exp_taken = 1'b1;
            exp_target = if_pc + b_imm(if_inst);
        end
    endtask

    task automatic model_update();
        logic [7:0] u0, u1;
        logic [9:0] g0, g1;
        logic       m0, m1;
        if (ex_valid) begin
            u0 = ex_pc[7:0] ^ ex_hist[7:0];
            u1 = ex_pc[7:0] ^ ex_hist[15:8];
            g0 = ex_pc[17:8] ^ ex_hist[15:6];
            g1 = ex_pc[17:8] ^ {2'b00, ex_hist[7:0]};
            m0 = (m_t0_tag[u0] == g0);  // full tag, before any write
            m1 = (m_t1_tag[u1] == g1);
            m_bim[ex_pc[9:1]] = step_ctr(m_bim[ex_pc[9:1]], ex_taken);
            if (ex_prov == PROV_T0) begin
                m_t0_ctr[u0] = ex_correct ? step_ctr(m_t0_ctr[u0], ex_taken) : {2{ex_taken}};
            end else if (ex_prov == PROV_T1) begin
                m_t1_ctr[u1] = ex_correct ? step_ctr(m_t1_ctr[u1], ex_taken) : {2{ex_taken}};
            end else if (!ex_correct) begin
                if (!m1) begin
                    m_t1_tag[u1] = g1;
                    m_t1_ctr[u1] = {ex_taken, ~ex_taken};
                end else if (!m0) begin
                    m_t0_tag[u0] = g0;
                    m_t0_ctr[u0] = {ex_taken, ~ex_taken};
                end
            end
            m_hist = {m_hist[14:0], ex_taken};
        end
        // pop first, then push into the freed slot
        if (ex_valid && ex_taken && !stall && (ex_inst[6:0] == 7'h67) && link_rs1(ex_inst)
            && m_sp > 0) begin
            m_sp--;
        end
        if (push_valid && !stall && m_sp < 64) begin
            m_stack[m_sp] = push_data;
            m_sp++;
        end
    endtask

    // inputs already set at the falling edge; check, update model, move to next falling edge
    task automatic cycle();
        #1;
        model_predict();
        check_val("branch_o", 32'(branch_o), 32'(exp_branch));
        check_val("taken_o", 32'(taken_o), 32'(exp_taken));
        check_val("target_o", target_o, exp_target);
        check_val("provider_o", 32'(provider_o), 32'(exp_prov));
        check_val("history_o", 32'(history_o), 32'(exp_hist));
        model_update();
        @(negedge clk);
    endtask

    task automatic do_reset();
        int n;
        rst = 1'b1;
        idle_inputs();
        for (int i = 0; i < 512; i++) m_bim[i] = 2'b01;
        for (int i = 0; i < 256; i++) begin
            m_t0_tag[i] = '0;
            m_t1_tag[i] = '0;
            m_t0_ctr[i] = 2'b01;
            m_t1_ctr[i] = 2'b01;
        end
        m_hist = '0;
        m_sp = 0;
        q_pc.delete();
        q_inst.delete();
        q_hist.delete();
        q_prov.delete();
        q_pred.delete();
        repeat (16) @(negedge clk);
        rst = 1'b0;
        n = 0;
        while (!(history_o === '0 && taken_o === 1'b0)) begin
            @(negedge clk);
            n++;
            if (n > 20) begin
                $display("timeout: outputs never settled after reset");
                $display("Some tests failed");
                $finish;
            end
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (test_err != 0) tests_failed++;
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (test_err == 0) ? "ok" : "FAIL", test_err);
        test_err = 0;
    endtask

    task automatic lookup(logic [31:0] pc, logic [31:0] inst);
        if_pc = pc;
        if_inst = inst;
        #1;
    endtask

    initial begin
        logic [31:0] r, a, b, c, pc;
        clk = 1'b0;
        checks = 0;
        errors = 0;
        test_err = 0;
        tests_run = 0;
        tests_failed = 0;
        do_reset();

        // 1: non-control words fall through
        for (int i = 0; i < 50; i++) begin
            r = next_rand();
            lookup({next_rand() & 32'hffff_fffc}, {r[31:7], 7'b0110011});
            check_val("taken_o", 32'(taken_o), 0);
            check_val("target_o", target_o, if_pc + 32'd4);
            cycle();
        end
        end_test("non-control");

        // 2: jal, conditional branch and plain jalr
        for (int i = 0; i < 60; i++) begin
            r = next_rand();
            pc = next_rand() & 32'h0003_fffc;
            case (i % 3)
                0: begin
                    lookup(pc, {r[31:7], 7'h6f});
                    check_val("taken_o", 32'(taken_o), 1);
                    check_val("target_o", target_o, pc + j_imm(if_inst));
                end
                1: lookup(pc, {r[31:7], 7'h63});
                default: begin
                    lookup(pc, {r[31:20], 5'd7, r[14:12], 5'd1, 7'h67});
                    check_val("taken_o", 32'(taken_o), 0);
                    check_val("target_o", target_o, pc + 32'd4);
                end
            endcase
            cycle();
        end
        end_test("control");

        // 3: return stack
        do_reset();
        lookup(32'h100, RET);
        check_val("taken_o", 32'(taken_o), 0);   // empty stack
        cycle();
        a = next_rand();
        b = next_rand();
        c = next_rand();
        push_valid = 1'b1;
        push_data = a;
        cycle();
        push_data = b;
        cycle();
        push_data = c;
        cycle();
        push_valid = 1'b0;
        lookup(32'h200, RET);
        check_val("target_o", target_o, c);
        cycle();
        ex_valid = 1'b1;
        ex_taken = 1'b1;
        ex_correct = 1'b1;
        ex_inst = RET;
        ex_pc = 32'h200;
        cycle();
        ex_valid = 1'b0;
        ex_taken = 1'b0;
        lookup(32'h204, RET);
        check_val("target_o", target_o, b);
        push_valid = 1'b1;
        push_data = next_rand();
        stall = 1'b1;
        #1;
        check_val("target_o", target_o, b);     // stalled push has no effect
        cycle();
        push_valid = 1'b0;
        stall = 1'b0;
        lookup(32'h208, RET);
        check_val("target_o", target_o, b);
        a = next_rand();
        push_valid = 1'b1;
        push_data = a;
        #1;
        check_val("target_o", target_o, a);     // same-cycle bypass
        cycle();
        push_valid = 1'b0;
        lookup(32'h20c, RET);
        check_val("target_o", target_o, a);
        cycle();
        end_test("return stack");

        // 4: bimodal training, replayed history keeps T1 allocations elsewhere
        do_reset();
        pc = 32'h0003_0100;
        for (int i = 0; i < 3; i++) begin
            lookup(pc, 32'h0000_0063);
            check_val("provider_o", 32'(provider_o), 32'(PROV_BIMODAL));
            ex_valid = 1'b1;
            ex_taken = 1'b1;
            ex_pc = pc;
            ex_hist = 16'h5a00;
            ex_prov = PROV_BIMODAL;
            ex_correct = (taken_o == 1'b1);
            cycle();
        end
        ex_valid = 1'b0;
        lookup(pc, 32'h0000_0063);
        check_val("taken_o", 32'(taken_o), 1);
        check_val("provider_o", 32'(provider_o), 32'(PROV_BIMODAL));
        cycle();
        end_test("bimodal training");

        // 5: bimodal miss allocates in T1
        do_reset();
        pc = 32'h0003_0200;
        lookup(pc, 32'h0000_0063);
        check_val("provider_o", 32'(provider_o), 32'(PROV_BIMODAL));
        check_val("taken_o", 32'(taken_o), 0);
        ex_valid = 1'b1;
        ex_taken = 1'b1;
        ex_correct = 1'b0;
        ex_pc = pc;
        ex_hist = history_o;
        ex_prov = PROV_BIMODAL;
        cycle();
        ex_valid = 1'b0;
        lookup(pc, 32'h0000_0063);
        check_val("provider_o", 32'(provider_o), 32'(PROV_T1));
        check_val("taken_o", 32'(taken_o), 1);  // weak taken after allocation
        ex_valid = 1'b1;
        ex_taken = 1'b0;
        ex_correct = 1'b0;
        ex_pc = pc;
        ex_hist = history_o;
        ex_prov = PROV_T1;
        cycle();
        ex_valid = 1'b0;
        lookup(pc, 32'h0000_0063);
        check_val("provider_o", 32'(provider_o), 32'(PROV_T1));
        check_val("taken_o", 32'(taken_o), 0);  // reset to strong not taken
        cycle();
        end_test("T1 allocation");

        // 6: long random run, every output against the model
        do_reset();
        for (int i = 0; i < 3000; i++) begin
            idle_inputs();
            r = next_rand();
            if_pc = {14'd0, r[17:2], 2'b00};
            a = next_rand();
            case (r[20:18])
                0, 1, 2: if_inst = {a[31:7], 7'h63};
                3:       if_inst = {a[31:7], 7'h6f};
                4:       if_inst = a[0] ? RET : 32'h0002_8067;
                5:       if_inst = {a[31:7], 7'h67};
                default: if_inst = {a[31:7], 7'b0110011};
            endcase
            b = next_rand();
            push_valid = b[0] & b[1];
            push_data = next_rand();
            stall = b[2] & b[3] & b[4];
            if (q_pc.size() > 0 && (b[5] || q_pc.size() > 32)) begin
                ex_valid = 1'b1;
                ex_taken = b[6];
                ex_pc = q_pc.pop_front();
                ex_inst = q_inst.pop_front();
                ex_hist = q_hist.pop_front();
                ex_prov = provider_e'(q_prov.pop_front());
                ex_correct = (q_pred.pop_front() == b[6]);
            end
            cycle();
            if (exp_branch) begin
                q_pc.push_back(if_pc);
                q_inst.push_back(if_inst);
                q_hist.push_back(exp_hist);
                q_prov.push_back(exp_prov);
                q_pred.push_back(exp_taken);
            end
        end
        end_test("random run");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+common
common/bpu_pkg.sv
common/bpu_update_if.sv
logic/inst_decode.sv
tage/bimodal_table.sv
tage/tagged_table.sv
tage/tage_predictor.sv
ras/return_stack.sv
logic/target_select.sv
logic/bpu_top.sv
verification/tb_bpu.sv

// File: Makefile
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module tb_bpu

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_bpu -o Vtb_bpu
	./obj_dir/Vtb_bpu > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "All tests passed" $(LOG) || (echo "no result in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
